/* source/ex_pkg.sv */
`default_nettype none

package ex_pkg;

  // A data word is sixteen bits wide and moves as four 4-bit slices.
  typedef logic [15:0] word_t;
  typedef logic [3:0]  slice_t;

  // The beat counter selects the slice. Zero is the least significant slice.
  typedef logic [1:0]  ctr_t;

  // Register index, opcode and conditional-execution state.
  typedef logic [3:0]  reg_t;
  typedef logic [3:0]  op_t;
  typedef logic [7:0]  cond_t;

  // ALU operation select.
  typedef logic [1:0]  alu_op_t;

  // Opcodes live in bits 15:12 of the encoding. Values 14 and 15 do nothing.
  localparam op_t OP_ADD     = 4'd0;
  localparam op_t OP_SUB     = 4'd1;
  localparam op_t OP_AND     = 4'd2;
  localparam op_t OP_OR      = 4'd3;
  localparam op_t OP_XOR     = 4'd4;
  localparam op_t OP_CMP_EQ  = 4'd5;
  localparam op_t OP_CMP_NE  = 4'd6;
  localparam op_t OP_CMP_LT  = 4'd7;
  localparam op_t OP_CMP_LTU = 4'd8;
  localparam op_t OP_CMP_GE  = 4'd9;
  localparam op_t OP_CMP_GEU = 4'd10;
  localparam op_t OP_COND    = 4'd11;
  localparam op_t OP_URX     = 4'd12;
  localparam op_t OP_UTX     = 4'd13;

  // Register 0 always reads as zero and ignores writes.
  localparam reg_t REG_ZR = 4'd0;

  // Counter value of the final slice in a beat.
  localparam ctr_t CTR_LAST = 2'd3;

  // ALU operations.
  localparam alu_op_t ALU_ADD = 2'd0;
  localparam alu_op_t ALU_AND = 2'd1;
  localparam alu_op_t ALU_OR  = 2'd2;
  localparam alu_op_t ALU_XOR = 2'd3;

  // Decoded control for the instruction held in the current beat.
  typedef struct packed {
    logic    vld;
    op_t     op;
    reg_t    dst;
    reg_t    lhs;
    reg_t    rhs;
    cond_t   cond;
    alu_op_t alu_op;
    logic    alu_inv;
    logic    alu_cin;
    logic    wr_reg;
    logic    is_cmp;
    logic    is_cond;
    logic    is_urx;
    logic    is_utx;
  } ctrl_t;

  // ALU flags for the whole word, valid in the last cycle of a beat.
  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } flags_t;

endpackage

`default_nettype wire

/* source/ex_issue.sv */
`default_nettype none

// Beat counter, instruction register and decode.
module ex_issue import ex_pkg::*; (
  input  var logic  i_ex_gck,
  input  var logic  i_ex_rst_n,
  input  var word_t i_enc,
  input  var logic  i_enc_vld,
  input  var logic  i_stall,
  output var ctr_t  o_ctr,
  output var ctrl_t o_ctrl
);

  // Free-running beat counter.
  ctr_t  ctr_q;

  // Held instruction and whether it is valid.
  word_t enc_q;
  logic  vld_q;

  // Opcode field of the held encoding.
  op_t   op;

  // The counter wraps every four cycles and starts from zero after reset.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + ctr_t'(1);
    end
  end

  // A new instruction is taken at the end of a beat when nothing is held or
  // the held instruction was not stalled. A stalled one is kept and retried.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      vld_q <= 1'b0;
    end else if (ctr_q == CTR_LAST && (!vld_q || !i_stall)) begin
      vld_q <= i_enc_vld;
    end
  end

  // The encoding itself is payload.
  always_ff @(posedge i_ex_gck) begin
    if (ctr_q == CTR_LAST && (!vld_q || !i_stall)) begin
      enc_q <= i_enc;
    end
  end

  always_comb op = op_t'(enc_q[15:12]);

  // Decode the held encoding. Fields are passed through and then the
  // opcode sets up the ALU and the kind of instruction.
  always_comb begin
    o_ctrl         = '0;
    o_ctrl.vld     = vld_q;
    o_ctrl.op      = op;
    o_ctrl.dst     = enc_q[11:8];
    o_ctrl.lhs     = enc_q[7:4];
    o_ctrl.rhs     = enc_q[3:0];
    o_ctrl.cond    = enc_q[7:0];
    o_ctrl.alu_op  = ALU_ADD;

    case (op)
      OP_ADD: o_ctrl.wr_reg = 1'b1;
      // Subtraction adds the inverted operand plus one.
      OP_SUB: begin
        o_ctrl.alu_inv = 1'b1;
        o_ctrl.alu_cin = 1'b1;
        o_ctrl.wr_reg  = 1'b1;
      end
      OP_AND: begin
        o_ctrl.alu_op = ALU_AND;
        o_ctrl.wr_reg = 1'b1;
      end
      OP_OR: begin
        o_ctrl.alu_op = ALU_OR;
        o_ctrl.wr_reg = 1'b1;
      end
      OP_XOR: begin
        o_ctrl.alu_op = ALU_XOR;
        o_ctrl.wr_reg = 1'b1;
      end
      // All comparisons are a subtraction that only produces flags.
      OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT, OP_CMP_LTU, OP_CMP_GE, OP_CMP_GEU: begin
        o_ctrl.alu_inv = 1'b1;
        o_ctrl.alu_cin = 1'b1;
        o_ctrl.is_cmp  = 1'b1;
      end
      OP_COND: o_ctrl.is_cond = 1'b1;
      OP_URX: begin
        o_ctrl.is_urx = 1'b1;
        o_ctrl.wr_reg = 1'b1;
      end
      // Transmit passes lhs through the ALU by ORing it with zero.
      OP_UTX: begin
        o_ctrl.alu_op = ALU_OR;
        o_ctrl.rhs    = REG_ZR;
        o_ctrl.is_utx = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb o_ctr = ctr_q;

  // The retry decision at the beat boundary sees only the last stall value,
  // so the stall of a held instruction must stay the same over the beat.
  a_stall_steady: assert property (
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    (ctr_q != CTR_LAST && vld_q) |=> $stable(i_stall)
  );

endmodule

`default_nettype wire

/* source/ex_regfile.sv */
`default_nettype none

// Register file of sixteen words, accessed one slice per cycle.
module ex_regfile import ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var ctr_t   i_ctr,
  input  var ctrl_t  i_ctrl,
  input  var logic   i_exec,
  input  var slice_t i_wr_data,
  output var slice_t o_lhs,
  output var slice_t o_rhs
);

  // Each register is stored as four slices so the counter picks one
  // directly. Entry 0 is never written.
  slice_t regs_q [16][4];

  // Write enable for the current slice.
  logic   wr_en;

  // Only executed instructions that produce a register result write, and a
  // write aimed at R0 is simply dropped.
  always_comb wr_en = i_exec && i_ctrl.wr_reg && i_ctrl.dst != REG_ZR;

  always_ff @(posedge i_ex_gck) begin
    if (wr_en) begin
      regs_q[i_ctrl.dst][i_ctr] <= i_wr_data;
    end
  end

  // Reads are combinational. A read of the register being written returns
  // the old slice, which is what the current instruction should see.
  always_comb begin
    if (i_ctrl.lhs == REG_ZR) begin
      o_lhs = '0;
    end else begin
      o_lhs = regs_q[i_ctrl.lhs][i_ctr];
    end
  end

  always_comb begin
    if (i_ctrl.rhs == REG_ZR) begin
      o_rhs = '0;
    end else begin
      o_rhs = regs_q[i_ctrl.rhs][i_ctr];
    end
  end

endmodule

`default_nettype wire

/* source/ex_alu.sv */
`default_nettype none

// Slice-serial ALU.
module ex_alu import ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var ctr_t   i_ctr,
  input  var ctrl_t  i_ctrl,
  input  var slice_t i_lhs,
  input  var slice_t i_rhs,
  output var slice_t o_out,
  output var flags_t o_flags
);

  // Right-hand operand after optional inversion.
  slice_t rhs;

  // Carry into this slice and the 5-bit sum with carry out.
  logic       cin;
  logic [4:0] sum;

  // Carry and zero state saved between slices.
  logic carry_q;
  logic zero_q;
  logic zero_acc;
  logic zero_now;

  always_comb rhs = i_ctrl.alu_inv ? ~i_rhs : i_rhs;

  // The first slice takes its carry from the decode, later slices from the
  // previous cycle.
  always_comb cin = (i_ctr == '0) ? i_ctrl.alu_cin : carry_q;

  always_comb sum = {1'b0, i_lhs} + {1'b0, rhs} + {4'b0, cin};

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_AND: o_out = i_lhs & rhs;
      ALU_OR:  o_out = i_lhs | rhs;
      ALU_XOR: o_out = i_lhs ^ rhs;
      default: o_out = sum[3:0];
    endcase
  end

  // Zero is tracked across the beat and restarts on the first slice.
  always_comb zero_acc = (i_ctr == '0) ? 1'b1 : zero_q;
  always_comb zero_now = zero_acc && (o_out == '0);

  always_ff @(posedge i_ex_gck) begin
    carry_q <= sum[4];
    zero_q  <= zero_now;
  end

  // Flags describe the whole word once the top slice is present at the last
  // counter value. Overflow is set when both operands share a sign and the
  // result does not.
  always_comb begin
    o_flags.z = zero_now;
    o_flags.n = o_out[3];
    o_flags.c = sum[4];
    o_flags.v = (i_lhs[3] == rhs[3]) && (o_out[3] != i_lhs[3]);
  end

endmodule

`default_nettype wire

/* source/ex_cond.sv */
`default_nettype none

// Predicate and conditional-execution state.
module ex_cond import ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,
  input  var ctr_t   i_ctr,
  input  var ctrl_t  i_ctrl,
  input  var logic   i_stall,
  input  var flags_t i_flags,
  output var logic   o_run,
  output var logic   o_exec
);

  // Predicate written by comparisons.
  logic  pred_q;
  logic  pred_d;

  // Run of condition bits, consumed from bit 0 upwards.
  cond_t cond_q;

  // Whether the held instruction is skipped.
  logic  skip;

  // The state only applies while any bit above bit 0 is set. Bit 0 then
  // names the predicate value the instruction needs in order to run.
  always_comb skip = |cond_q[7:1] && (cond_q[0] ? !pred_q : pred_q);

  always_comb o_run  = i_ctrl.vld && !i_stall;
  always_comb o_exec = o_run && !skip;

  // New predicate from an executed comparison.
  always_comb begin
    pred_d = pred_q;
    if (o_exec && i_ctrl.is_cmp) begin
      case (i_ctrl.op)
        OP_CMP_EQ:  pred_d = i_flags.z;
        OP_CMP_NE:  pred_d = !i_flags.z;
        OP_CMP_LT:  pred_d = i_flags.n != i_flags.v;
        OP_CMP_LTU: pred_d = !i_flags.c;
        OP_CMP_GE:  pred_d = i_flags.n == i_flags.v;
        OP_CMP_GEU: pred_d = i_flags.c;
        default:    pred_d = pred_q;
      endcase
    end
  end

  // Both pieces of state move only at the end of a beat that ran. An
  // executed COND loads a new value, every other instruction shifts the
  // state right, including a COND that was skipped.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
      cond_q <= '0;
    end else if (i_ctr == CTR_LAST && o_run) begin
      pred_q <= pred_d;
      if (i_ctrl.is_cond && !skip) begin
        cond_q <= i_ctrl.cond;
      end else begin
        cond_q <= {1'b0, cond_q[7:1]};
      end
    end
  end

endmodule

`default_nettype wire

/* source/ex_io_port.sv */
`default_nettype none

// UART strobes, stall and register write-data selection.
module ex_io_port import ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var ctr_t   i_ctr,
  input  var ctrl_t  i_ctrl,
  input  var logic   i_exec,
  input  var slice_t i_alu_out,
  input  var word_t  i_urx_data,
  input  var logic   i_urx_vld,
  input  var logic   i_utx_acp,
  output var logic   o_stall,
  output var slice_t o_wr_data,
  output var logic   o_urx_acp,
  output var slice_t o_utx_data,
  output var logic   o_utx_vld
);

  // Slice of the received word for the current counter value.
  slice_t urx_slice;

  // A held receive waits for data, a held transmit waits for the UART to
  // accept. The levels are steady over a beat, so the stall is too.
  always_comb begin
    o_stall = i_ctrl.vld
           && ((i_ctrl.is_urx && !i_urx_vld) || (i_ctrl.is_utx && !i_utx_acp));
  end

  // Strobes stay high for the whole executing beat.
  always_comb o_urx_acp = i_exec && i_ctrl.is_urx;
  always_comb o_utx_vld = i_exec && i_ctrl.is_utx;

  // Transmit data is lhs passed through the ALU, least significant slice
  // first.
  always_comb o_utx_data = i_alu_out;

  always_comb urx_slice = i_urx_data[{i_ctr, 2'b00} +: 4];

  // Received data goes straight into the register, everything else writes
  // the ALU result.
  always_comb o_wr_data = i_ctrl.is_urx ? urx_slice : i_alu_out;

  // The UART levels may only change at a beat boundary while an instruction
  // is held, otherwise the stall could flip part way through a beat.
  a_uart_levels_steady: assert property (
    @(posedge i_ex_gck)
    (i_ctrl.vld && i_ctr != CTR_LAST) |=> ($stable(i_urx_vld) && $stable(i_utx_acp))
  );

endmodule

`default_nettype wire

/* source/ex_top.sv */
`default_nettype none

// Execution unit of the nibble-serial processor.
module ex_top import ex_pkg::*; (
  // Clock and reset.
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  // Instruction source and beat counter.
  input  var word_t  i_ex_enc,
  input  var logic   i_ex_enc_vld,
  output var ctr_t   o_ex_ctr,
  output var logic   o_ex_stall,

  // UART receive side.
  input  var word_t  i_ex_urx_data,
  input  var logic   i_ex_urx_vld,
  output var logic   o_ex_urx_acp,

  // UART transmit side.
  output var slice_t o_ex_utx_data,
  output var logic   o_ex_utx_vld,
  input  var logic   i_ex_utx_acp
);

  // Decoded instruction for the current beat.
  ctrl_t  ctrl;

  // Operand slices and ALU result.
  slice_t lhs;
  slice_t rhs;
  slice_t alu_out;
  flags_t flags;

  // Execute level from the condition block.
  logic   exec;

  // Slice written back into the register file.
  slice_t wr_data;

  // Counter and instruction register.
  ex_issue u_issue (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_enc      (i_ex_enc),
    .i_enc_vld  (i_ex_enc_vld),
    .i_stall    (o_ex_stall),
    .o_ctr      (o_ex_ctr),
    .o_ctrl     (ctrl)
  );

  // Register file.
  ex_regfile u_regfile (
    .i_ex_gck  (i_ex_gck),
    .i_ctr     (o_ex_ctr),
    .i_ctrl    (ctrl),
    .i_exec    (exec),
    .i_wr_data (wr_data),
    .o_lhs     (lhs),
    .o_rhs     (rhs)
  );

  // Slice ALU.
  ex_alu u_alu (
    .i_ex_gck (i_ex_gck),
    .i_ctr    (o_ex_ctr),
    .i_ctrl   (ctrl),
    .i_lhs    (lhs),
    .i_rhs    (rhs),
    .o_out    (alu_out),
    .o_flags  (flags)
  );

  // Predicate and conditional-execution state.
  ex_cond u_cond (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_ctr      (o_ex_ctr),
    .i_ctrl     (ctrl),
    .i_stall    (o_ex_stall),
    .i_flags    (flags),
    .o_run      (),
    .o_exec     (exec)
  );

  // UART strobes, stall and write-back selection.
  ex_io_port u_io_port (
    .i_ex_gck   (i_ex_gck),
    .i_ctr      (o_ex_ctr),
    .i_ctrl     (ctrl),
    .i_exec     (exec),
    .i_alu_out  (alu_out),
    .i_urx_data (i_ex_urx_data),
    .i_urx_vld  (i_ex_urx_vld),
    .i_utx_acp  (i_ex_utx_acp),
    .o_stall    (o_ex_stall),
    .o_wr_data  (wr_data),
    .o_urx_acp  (o_ex_urx_acp),
    .o_utx_data (o_ex_utx_data),
    .o_utx_vld  (o_ex_utx_vld)
  );

endmodule

`default_nettype wire

/* tests/tb_top.sv */
`default_nettype none

module tb_top import ex_pkg::*; ;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_INSTR        = 300;
  localparam int N_LOAD         = 15;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = N_INSTR * 5 * 4 + RESET_CYCLES;
  localparam logic [31:0] SEED  = 32'hfb3db964;

  // DUT inputs and outputs.
  logic   i_ex_gck = 1'b0;
  logic   i_ex_rst_n;
  word_t  i_ex_enc;
  logic   i_ex_enc_vld;
  ctr_t   o_ex_ctr;
  logic   o_ex_stall;
  word_t  i_ex_urx_data;
  logic   i_ex_urx_vld;
  logic   o_ex_urx_acp;
  slice_t o_ex_utx_data;
  logic   o_ex_utx_vld;
  logic   i_ex_utx_acp;

  // Program and the model of the architectural state.
  word_t prog [N_INSTR];
  word_t m_regs [16];
  logic  m_pred;
  cond_t m_cond;

  // Issue bookkeeping. Indices equal to N_INSTR mean no instruction.
  int    pres_idx;
  int    held_idx;
  int    exec_count;
  int    drain_beats;
  int    cycle_count = 0;

  // UART levels for the coming beat and how long each has been held off.
  logic  urx_on;
  logic  utx_on;
  word_t rx_word;
  int    urx_off_run;
  int    utx_off_run;

  // What the DUT outputs should show during the current beat.
  logic  exp_stall = 1'b0;
  logic  exp_urx = 1'b0;
  logic  exp_utx = 1'b0;
  ctr_t  exp_ctr = '0;
  word_t tx_exp_q [$];
  word_t tx_acc;
  int    tx_seen = 0;
  int unsigned seed_val;

  ex_top u_dut (
    .i_ex_gck      (i_ex_gck),
    .i_ex_rst_n    (i_ex_rst_n),
    .i_ex_enc      (i_ex_enc),
    .i_ex_enc_vld  (i_ex_enc_vld),
    .o_ex_ctr      (o_ex_ctr),
    .o_ex_stall    (o_ex_stall),
    .i_ex_urx_data (i_ex_urx_data),
    .i_ex_urx_vld  (i_ex_urx_vld),
    .o_ex_urx_acp  (o_ex_urx_acp),
    .o_ex_utx_data (o_ex_utx_data),
    .o_ex_utx_vld  (o_ex_utx_vld),
    .i_ex_utx_acp  (i_ex_utx_acp)
  );

  // Period of 4 ns.
  always #2 i_ex_gck = ~i_ex_gck;

  // Single point where a wrong value ends the run.
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // Architectural effect of one instruction that runs. The return value says
  // whether a transmit word goes out, and tx holds that word.
  function automatic logic model_exec(input word_t enc, input word_t rx,
                                      output word_t tx, output logic rx_taken);
    op_t   op;
    reg_t  d;
    word_t a;
    word_t b;
    word_t res;
    logic  wr;
    logic  skip;
    logic  sends;
    op       = op_t'(enc[15:12]);
    d        = enc[11:8];
    a        = m_regs[enc[7:4]];
    b        = m_regs[enc[3:0]];
    res      = '0;
    wr       = 1'b0;
    sends    = 1'b0;
    tx       = '0;
    rx_taken = 1'b0;
    // A skip needs a live run of condition bits and a predicate that
    // differs from the bit the instruction asks for.
    skip = (m_cond[7:1] != 7'd0) && (m_cond[0] != m_pred);
    if (skip) begin
      m_cond = m_cond >> 1;
    end else begin
      case (op)
        OP_ADD:     begin res = a + b; wr = 1'b1; end
        OP_SUB:     begin res = a - b; wr = 1'b1; end
        OP_AND:     begin res = a & b; wr = 1'b1; end
        OP_OR:      begin res = a | b; wr = 1'b1; end
        OP_XOR:     begin res = a ^ b; wr = 1'b1; end
        OP_CMP_EQ:  m_pred = (a == b);
        OP_CMP_NE:  m_pred = (a != b);
        OP_CMP_LT:  m_pred = ($signed(a) < $signed(b));
        OP_CMP_LTU: m_pred = (a < b);
        OP_CMP_GE:  m_pred = ($signed(a) >= $signed(b));
        OP_CMP_GEU: m_pred = (a >= b);
        OP_URX:     begin res = rx; wr = 1'b1; rx_taken = 1'b1; end
        OP_UTX:     begin tx = a; sends = 1'b1; end
        default: ;
      endcase
      // R0 keeps its zero.
      if (wr && d != REG_ZR) begin
        m_regs[d] = res;
      end
      if (op == OP_COND) begin
        m_cond = enc[7:0];
      end else begin
        m_cond = m_cond >> 1;
      end
    end
    return sends;
  endfunction

  // Loads R1 to R15, echoes them all once, then a random mix follows.
  task automatic build_program();
    int   sel;
    op_t  op;
    for (int i = 0; i < N_INSTR; i++) begin
      sel = int'($urandom % 20);
      if (i < N_LOAD) begin
        prog[i] = {OP_URX, reg_t'(i + 1), 8'h00};
      end else if (i < 2 * N_LOAD) begin
        prog[i] = {OP_UTX, 4'h0, reg_t'(i - N_LOAD + 1), 4'h0};
      end else if (sel < 7) begin
        op = op_t'($urandom % 5);
        prog[i] = {op, reg_t'($urandom % 16), reg_t'($urandom % 16), reg_t'($urandom % 16)};
      end else if (sel < 11) begin
        op = op_t'(5 + $urandom % 6);
        prog[i] = {op, 4'h0, reg_t'($urandom % 16), reg_t'($urandom % 16)};
      end else if (sel < 14) begin
        // Short condition runs keep both outcomes common.
        prog[i] = {OP_COND, 4'h0, 8'($urandom % 32)};
      end else if (sel < 19) begin
        prog[i] = {OP_UTX, 4'h0, reg_t'($urandom % 16), 4'h0};
      end else begin
        prog[i] = {op_t'(14 + $urandom % 2), 12'($urandom)};
      end
    end
  endtask

  // Each level drops with a chance of one in four, but never for more than
  // three beats in a row.
  task automatic pick_uart_levels();
    urx_on      = (urx_off_run >= 3) || ($urandom % 4 != 0);
    utx_on      = (utx_off_run >= 3) || ($urandom % 4 != 0);
    urx_off_run = urx_on ? 0 : urx_off_run + 1;
    utx_off_run = utx_on ? 0 : utx_off_run + 1;
    rx_word     = word_t'($urandom);
    i_ex_urx_vld  <= urx_on;
    i_ex_utx_acp  <= utx_on;
    i_ex_urx_data <= rx_word;
  endtask

  // Called at each edge that ends a beat. It mirrors the DUT's acceptance,
  // sets the UART levels for the next beat and predicts that beat.
  task automatic start_beat();
    op_t   op;
    word_t tx;
    logic  sends;
    logic  rx_taken;
    if (!exp_stall) begin
      held_idx = pres_idx;
      if (pres_idx < N_INSTR) begin
        pres_idx++;
      end
      if (pres_idx < N_INSTR) begin
        i_ex_enc     <= prog[pres_idx];
        i_ex_enc_vld <= 1'b1;
      end else begin
        i_ex_enc_vld <= 1'b0;
      end
    end
    pick_uart_levels();
    exp_stall = 1'b0;
    exp_urx   = 1'b0;
    exp_utx   = 1'b0;
    if (held_idx < N_INSTR) begin
      op = op_t'(prog[held_idx][15:12]);
      // The stall ignores the skip decision.
      exp_stall = (op == OP_URX && !urx_on) || (op == OP_UTX && !utx_on);
      if (!exp_stall) begin
        sends   = model_exec(prog[held_idx], rx_word, tx, rx_taken);
        exp_utx = sends;
        exp_urx = rx_taken;
        if (sends) begin
          tx_exp_q.push_back(tx);
        end
        exec_count++;
      end
    end
  endtask

  // Outputs are compared at the falling edge, half a cycle after they settle.
  always @(negedge i_ex_gck) begin
    if (i_ex_rst_n) begin
      check_value("o_ex_ctr", 32'(exp_ctr), 32'(o_ex_ctr));
      check_value("o_ex_stall", 32'(exp_stall), 32'(o_ex_stall));
      check_value("o_ex_urx_acp", 32'(exp_urx), 32'(o_ex_urx_acp));
      check_value("o_ex_utx_vld", 32'(exp_utx), 32'(o_ex_utx_vld));
      if (o_ex_utx_vld) begin
        tx_acc[{o_ex_ctr, 2'b00} +: 4] = o_ex_utx_data;
        if (o_ex_ctr == CTR_LAST) begin
          check_value("o_ex_utx_data word", 32'(tx_exp_q[tx_seen]), 32'(tx_acc));
          tx_seen++;
        end
      end
      exp_ctr = exp_ctr + ctr_t'(1);
    end
  end

  // Worst case is four beats per instruction, so five leaves margin.
  always @(posedge i_ex_gck) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: the program did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    seed_val = $urandom(SEED);
    build_program();
    for (int r = 0; r < 16; r++) begin
      m_regs[r] = '0;
    end
    m_pred      = 1'b0;
    m_cond      = '0;
    pres_idx    = 0;
    held_idx    = N_INSTR;
    exec_count  = 0;
    drain_beats = 0;
    urx_off_run = 0;
    utx_off_run = 0;
    // The first encoding waits at the input while reset is held.
    i_ex_rst_n    <= 1'b0;
    i_ex_enc      <= prog[0];
    i_ex_enc_vld  <= 1'b1;
    i_ex_urx_data <= '0;
    i_ex_urx_vld  <= 1'b0;
    i_ex_utx_acp  <= 1'b0;
    repeat (RESET_CYCLES) @(posedge i_ex_gck);
    i_ex_rst_n <= 1'b1;

    // The loop ends at the edge that closes the beat of the last
    // instruction, so the checker has seen every slice of it.
    while (drain_beats < 2) begin
      @(posedge i_ex_gck);
      if (o_ex_ctr == CTR_LAST) begin
        start_beat();
        if (exec_count == N_INSTR) begin
          drain_beats++;
        end
      end
    end

    $display("Program done, %0d transmit words checked", tx_seen);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
source/ex_pkg.sv
source/ex_issue.sv
source/ex_regfile.sv
source/ex_alu.sv
source/ex_cond.sv
source/ex_io_port.sv
source/ex_top.sv
tests/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top -f sources.f -o sim_tb_top

status=0
output=$(./obj_dir/sim_tb_top 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -q "^TEST OK$" <<< "$output"; then
  exit 0
fi
exit 1
